//--- Bender.yml
package:
  name: l1_cache

sources:
  - cache_pkg.sv
  - cache_tag_store.sv
  - cache_data_ram.sv
  - cache_write_ctrl.sv
  - cache_read_out.sv
  - l1_cache.sv
  - target: simulation
    files:
      - tb_l1_cache.sv

//--- cache_data_ram.sv
/*
	Data RAM of one way, one line per set
	One write port with byte enables, one registered read port
	Read and write of the same entry in one cycle give undefined data
*/
`timescale 1ns/1ps

module cache_data_ram (
	input  logic iCLOCK,
	input  logic wr_en,
	input  logic [cache_pkg::INDEX_W-1:0] wr_index,
	input  logic [cache_pkg::INDEX_W-1:0] rd_index,
	input  logic [cache_pkg::LINE_BYTES-1:0] byte_en,
	input  cache_pkg::line_t wr_data,
	output cache_pkg::line_t rd_data
);

	logic [cache_pkg::LINE_W-1:0] mem [cache_pkg::SETS];
	logic [cache_pkg::LINE_W-1:0] wr_vec;

	assign wr_vec = wr_data;

	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			for (int b = 0; b < cache_pkg::LINE_BYTES; b++) begin
				if (byte_en[b]) begin
					mem[wr_index][8*b +: 8] <= wr_vec[8*b +: 8];
				end
			end
		end
	end

	// Registered read, data one cycle after the index
	always_ff @(posedge iCLOCK) begin
		rd_data <= mem[rd_index];
	end

endmodule

//--- cache_pkg.sv
/*
	Geometry and shared types of the 4-way, 16-set L1 cache
	Byte addresses split as tag | set index | byte offset
	Lines are little endian, byte 0 sits in bits 7:0
*/
package cache_pkg;

	localparam int ADDR_W = 32;
	localparam int WAYS = 4;
	localparam int SETS = 16;
	localparam int LINE_BYTES = 64;

	localparam int INDEX_W = $clog2(SETS);
	localparam int OFFSET_W = $clog2(LINE_BYTES);
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;	// 22 bits
	localparam int WAY_W = $clog2(WAYS);

	localparam int LINE_W = LINE_BYTES * 8;
	localparam int DWORD_W = 64;	// Read port
	localparam int WORD_W = 32;	// Store data

	// Line status, 0 is invalid and 1 to 3 is the age
	localparam int STATUS_W = 2;
	localparam logic [STATUS_W-1:0] ST_INVALID = 2'd0;
	localparam logic [STATUS_W-1:0] ST_NEWEST = 2'd3;

	// One cache line seen as doublewords or as words
	typedef union packed {
		logic [LINE_W/DWORD_W-1:0][DWORD_W-1:0] dword;	// Read select
		logic [LINE_W/WORD_W-1:0][WORD_W-1:0] word;	// Store replicate
	} line_t;

	// Store size, 0 byte, 1 half, 2 word, 3 no write
	typedef logic [1:0] order_t;

endpackage

//--- cache_read_out.sv
/*
	Read result buffer and doubleword select
	While rd_lock is high all outputs are masked and the buffer holds
	Data from the RAM must arrive one cycle after the request
*/
`timescale 1ns/1ps

module cache_read_out (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic iREMOVE,
	input  logic rd_req,
	input  logic rd_lock,
	input  logic [cache_pkg::ADDR_W-1:0] rd_addr,
	input  logic rd_hit,
	input  logic [cache_pkg::WAY_W-1:0] rd_way,
	input  cache_pkg::line_t [cache_pkg::WAYS-1:0] way_data,
	output logic oRD_VALID,
	output logic oRD_HIT,
	output logic [cache_pkg::DWORD_W-1:0] oRD_DATA
);

	localparam int DW_LSB = $clog2(cache_pkg::DWORD_W / 8);
	localparam int DW_SEL_W = cache_pkg::OFFSET_W - DW_LSB;

	logic req_q;
	logic hit_q;
	logic [cache_pkg::WAY_W-1:0] way_q;
	logic [DW_SEL_W-1:0] dw_q;
	cache_pkg::line_t sel_line;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			req_q <= 1'b0;
			hit_q <= 1'b0;
		end
		else if (iREMOVE) begin
			req_q <= 1'b0;
			hit_q <= 1'b0;
		end
		else if (!rd_lock) begin
			req_q <= rd_req;
			hit_q <= rd_hit;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!rd_lock) begin
			way_q <= rd_way;
			dw_q <= rd_addr[DW_LSB +: DW_SEL_W];	// Doubleword within the line
		end
	end

	assign sel_line = way_data[way_q];

	assign oRD_VALID = req_q && !rd_lock;
	assign oRD_HIT = oRD_VALID && hit_q;
	assign oRD_DATA = oRD_HIT ? sel_line.dword[dw_q] : '0;

endmodule

//--- cache_tag_store.sv
/*
	Tag and status arrays for all ways and sets
	Lookups are combinational, updates take one edge
	Flush and reset clear the statuses, tags keep their old value
	Ageing tick every AGE_PERIOD cycles with the read port not stalled
*/
`timescale 1ns/1ps

module cache_tag_store #(
	parameter int unsigned AGE_PERIOD = 65536
)(
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic iREMOVE,
	input  logic rd_req,
	input  logic rd_lock,
	input  logic [cache_pkg::ADDR_W-1:0] rd_addr,
	input  logic [cache_pkg::ADDR_W-1:0] wr_addr,
	input  logic [cache_pkg::ADDR_W-1:0] up_addr,
	input  logic wr_en,
	input  logic up_req,
	output logic rd_hit,
	output logic up_hit,
	output logic [cache_pkg::WAY_W-1:0] rd_way,
	output logic [cache_pkg::WAY_W-1:0] up_way,
	output logic [cache_pkg::WAY_W-1:0] fill_way
);

	localparam int CNT_W = (AGE_PERIOD > 1) ? $clog2(AGE_PERIOD) : 1;

	logic [cache_pkg::TAG_W-1:0] tag_q [cache_pkg::WAYS][cache_pkg::SETS];
	logic [cache_pkg::STATUS_W-1:0] status_q [cache_pkg::WAYS][cache_pkg::SETS];
	logic [CNT_W-1:0] age_cnt;
	logic age_tick;
	logic store_hit;
	logic [cache_pkg::INDEX_W-1:0] rd_idx;
	logic [cache_pkg::INDEX_W-1:0] wr_idx;
	logic [cache_pkg::INDEX_W-1:0] up_idx;
	logic [cache_pkg::TAG_W-1:0] rd_tag;
	logic [cache_pkg::TAG_W-1:0] wr_tag;
	logic [cache_pkg::TAG_W-1:0] up_tag;

	assign rd_idx = rd_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
	assign wr_idx = wr_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
	assign up_idx = up_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
	assign rd_tag = rd_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
	assign wr_tag = wr_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
	assign up_tag = up_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];

	assign store_hit = up_req && up_hit;

	// Scan from the top so the lowest matching way is kept
	always_comb begin
		rd_hit = 1'b0;
		rd_way = '0;
		up_hit = 1'b0;
		up_way = '0;
		for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
			if (tag_q[w][rd_idx] == rd_tag && status_q[w][rd_idx] != cache_pkg::ST_INVALID) begin
				rd_hit = 1'b1;
				rd_way = cache_pkg::WAY_W'(w);
			end
			if (tag_q[w][up_idx] == up_tag && status_q[w][up_idx] != cache_pkg::ST_INVALID) begin
				up_hit = 1'b1;
				up_way = cache_pkg::WAY_W'(w);
			end
		end
	end

	// Victim search, later loops override earlier ones
	always_comb begin
		fill_way = cache_pkg::WAY_W'(cache_pkg::WAYS - 1);	// All lines newest
		for (int lvl = int'(cache_pkg::ST_NEWEST) - 1; lvl >= 0; lvl--) begin
			for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
				if (status_q[w][wr_idx] == cache_pkg::STATUS_W'(lvl)) begin
					fill_way = cache_pkg::WAY_W'(w);
				end
			end
		end
		// Refill of a known tag reuses its way, valid or not
		for (int w = cache_pkg::WAYS - 1; w >= 0; w--) begin
			if (tag_q[w][wr_idx] == wr_tag) begin
				fill_way = cache_pkg::WAY_W'(w);
			end
		end
	end

	assign age_tick = !rd_lock && (age_cnt == CNT_W'(AGE_PERIOD - 1));

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			age_cnt <= '0;
		end
		else if (iREMOVE) begin
			age_cnt <= '0;
		end
		else if (!rd_lock) begin
			age_cnt <= age_tick ? '0 : age_cnt + 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (wr_en && !iREMOVE) begin	// Flush drops a fill in the same cycle
			tag_q[fill_way][wr_idx] <= wr_tag;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < cache_pkg::WAYS; w++) begin
				for (int s = 0; s < cache_pkg::SETS; s++) begin
					status_q[w][s] <= cache_pkg::ST_INVALID;
				end
			end
		end
		else if (iREMOVE) begin
			for (int w = 0; w < cache_pkg::WAYS; w++) begin
				for (int s = 0; s < cache_pkg::SETS; s++) begin
					status_q[w][s] <= cache_pkg::ST_INVALID;
				end
			end
		end
		else if (store_hit) begin
			if (status_q[up_way][up_idx] != cache_pkg::ST_NEWEST) begin
				status_q[up_way][up_idx] <= status_q[up_way][up_idx] + 1'b1;	// Saturates at 3
			end
		end
		else if (wr_en) begin
			status_q[fill_way][wr_idx] <= cache_pkg::ST_NEWEST;
		end
		else if (!rd_lock) begin
			if (age_tick) begin
				for (int w = 0; w < cache_pkg::WAYS; w++) begin
					for (int s = 0; s < cache_pkg::SETS; s++) begin
						if (status_q[w][s] > cache_pkg::STATUS_W'(1)) begin
							status_q[w][s] <= status_q[w][s] - 1'b1;
						end
					end
				end
			end
			// Placed after ageing so a read hit line stays newest
			if (rd_req && rd_hit) begin
				status_q[rd_way][rd_idx] <= cache_pkg::ST_NEWEST;
			end
		end
	end

endmodule

//--- cache_write_ctrl.sv
/*
	Write port control shared by fills and stores
	A store owns the port in its cycle, a pending fill waits
	Stores must not cross the line end, extra bytes are dropped
*/
`timescale 1ns/1ps

module cache_write_ctrl (
	input  logic wr_req,
	input  logic up_req,
	input  logic [cache_pkg::ADDR_W-1:0] wr_addr,
	input  logic [cache_pkg::ADDR_W-1:0] up_addr,
	input  cache_pkg::line_t wr_data,
	input  cache_pkg::order_t up_order,
	input  logic [cache_pkg::WORD_W-1:0] up_data,
	input  logic up_hit,
	input  logic [cache_pkg::WAY_W-1:0] up_way,
	input  logic [cache_pkg::WAY_W-1:0] fill_way,
	output logic [cache_pkg::WAYS-1:0] way_wr_en,
	output logic wr_en,
	output logic [cache_pkg::LINE_BYTES-1:0] byte_en,
	output cache_pkg::line_t line_data,
	output logic [cache_pkg::INDEX_W-1:0] wr_index
);

	logic store_en;
	logic [cache_pkg::OFFSET_W-1:0] up_off;
	logic [cache_pkg::LINE_BYTES-1:0] size_mask;

	assign wr_en = wr_req && !up_req;	// Fill actually done
	assign store_en = up_req && up_hit;	// Store miss writes nothing
	assign up_off = up_addr[cache_pkg::OFFSET_W-1:0];

	always_comb begin
		case (up_order)
			2'd0: size_mask = cache_pkg::LINE_BYTES'(4'h1);
			2'd1: size_mask = cache_pkg::LINE_BYTES'(4'h3);
			2'd2: size_mask = cache_pkg::LINE_BYTES'(4'hF);
			default: size_mask = '0;
		endcase
	end

	assign byte_en = up_req ? (size_mask << up_off) : '1;

	// Store word copied to every word slot, byte enables pick the lanes
	always_comb begin
		line_data = wr_data;
		if (up_req) begin
			for (int i = 0; i < cache_pkg::LINE_W / cache_pkg::WORD_W; i++) begin
				line_data.word[i] = up_data;
			end
		end
	end

	assign wr_index = up_req ? up_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W]
	                         : wr_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];

	always_comb begin
		for (int w = 0; w < cache_pkg::WAYS; w++) begin
			way_wr_en[w] = (store_en && up_way == cache_pkg::WAY_W'(w))
			            || (wr_en && fill_way == cache_pkg::WAY_W'(w));
		end
	end

endmodule

//--- filelist.f
cache_pkg.sv
cache_tag_store.sv
cache_data_ram.sv
cache_write_ctrl.sv
cache_read_out.sv
l1_cache.sv
tb_l1_cache.sv

//--- l1_cache.sv
/*
	Write-through L1 cache, 4 ways by 16 sets of 64-byte lines
	Stores that miss are dropped, a fill waits while a store is presented
	Read data follows an accepted request by one cycle, iRD_BUSY stalls it
	Flush clears all statuses in one cycle
*/
`timescale 1ns/1ps

module l1_cache #(
	parameter int unsigned AGE_PERIOD = 65536
)(
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic iREMOVE,
	input  logic iRD_REQ,
	output logic oRD_BUSY,
	input  logic [cache_pkg::ADDR_W-1:0] iRD_ADDR,
	output logic oRD_VALID,
	output logic oRD_HIT,
	input  logic iRD_BUSY,
	output logic [cache_pkg::DWORD_W-1:0] oRD_DATA,
	input  logic iUP_REQ,
	input  cache_pkg::order_t iUP_ORDER,
	input  logic [cache_pkg::ADDR_W-1:0] iUP_ADDR,
	input  logic [cache_pkg::WORD_W-1:0] iUP_DATA,
	input  logic iWR_REQ,
	output logic oWR_BUSY,
	input  logic [cache_pkg::ADDR_W-1:0] iWR_ADDR,
	input  cache_pkg::line_t iWR_DATA
);

	logic rd_collide;
	logic rd_req;
	logic rd_hit;
	logic up_hit;
	logic wr_en;
	logic [cache_pkg::WAY_W-1:0] rd_way;
	logic [cache_pkg::WAY_W-1:0] up_way;
	logic [cache_pkg::WAY_W-1:0] fill_way;
	logic [cache_pkg::WAYS-1:0] way_wr_en;
	logic [cache_pkg::LINE_BYTES-1:0] byte_en;
	cache_pkg::line_t line_data;
	logic [cache_pkg::INDEX_W-1:0] wr_index;
	logic [cache_pkg::INDEX_W-1:0] rd_index;
	logic [cache_pkg::INDEX_W-1:0] rd_index_q;
	cache_pkg::line_t [cache_pkg::WAYS-1:0] way_data;

	// Read and fill of the same line in one cycle, the read waits
	assign rd_collide = iRD_REQ && iWR_REQ
	                 && iRD_ADDR[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W]
	                 == iWR_ADDR[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W];
	assign rd_req = iRD_REQ && !rd_collide;
	assign oRD_BUSY = iRD_BUSY || rd_collide;
	assign oWR_BUSY = iUP_REQ;

	// Keep reading the last set while stalled so the result reappears
	always_ff @(posedge iCLOCK) begin
		if (!iRD_BUSY) begin
			rd_index_q <= iRD_ADDR[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
		end
	end
	assign rd_index = iRD_BUSY ? rd_index_q
	                           : iRD_ADDR[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];

	cache_tag_store #(
		.AGE_PERIOD(AGE_PERIOD)
	) u_tag_store (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iREMOVE(iREMOVE),
		.rd_req(rd_req),
		.rd_lock(iRD_BUSY),
		.rd_addr(iRD_ADDR),
		.wr_addr(iWR_ADDR),
		.up_addr(iUP_ADDR),
		.wr_en(wr_en),
		.up_req(iUP_REQ),
		.rd_hit(rd_hit),
		.up_hit(up_hit),
		.rd_way(rd_way),
		.up_way(up_way),
		.fill_way(fill_way)
	);

	cache_write_ctrl u_write_ctrl (
		.wr_req(iWR_REQ),
		.up_req(iUP_REQ),
		.wr_addr(iWR_ADDR),
		.up_addr(iUP_ADDR),
		.wr_data(iWR_DATA),
		.up_order(iUP_ORDER),
		.up_data(iUP_DATA),
		.up_hit(up_hit),
		.up_way(up_way),
		.fill_way(fill_way),
		.way_wr_en(way_wr_en),
		.wr_en(wr_en),
		.byte_en(byte_en),
		.line_data(line_data),
		.wr_index(wr_index)
	);

	for (genvar w = 0; w < cache_pkg::WAYS; w++) begin : g_way
		cache_data_ram u_data_ram (
			.iCLOCK(iCLOCK),
			.wr_en(way_wr_en[w]),
			.wr_index(wr_index),
			.rd_index(rd_index),
			.byte_en(byte_en),
			.wr_data(line_data),
			.rd_data(way_data[w])
		);
	end

	cache_read_out u_read_out (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iREMOVE(iREMOVE),
		.rd_req(rd_req),
		.rd_lock(iRD_BUSY),
		.rd_addr(iRD_ADDR),
		.rd_hit(rd_hit),
		.rd_way(rd_way),
		.way_data(way_data),
		.oRD_VALID(oRD_VALID),
		.oRD_HIT(oRD_HIT),
		.oRD_DATA(oRD_DATA)
	);

endmodule

//--- tb_l1_cache.sv
/*
	Testbench for l1_cache with a short ageing period of 64 cycles
	A cycle-level reference model tracks tags, statuses and line bytes
	Stimulus avoids a flush in the same cycle as an accepted read
*/
`timescale 1ns/1ps

module tb_l1_cache;

	localparam int AGE = 64;
	localparam int LIMIT = 6 * 60 + 2 * AGE + 100;	// Six tests, two ageing periods, margin

	logic iCLOCK, inRESET, iREMOVE;
	logic iRD_REQ, iRD_BUSY, oRD_BUSY, oRD_VALID, oRD_HIT;
	logic [31:0] iRD_ADDR;
	logic [63:0] oRD_DATA;
	logic iWR_REQ, oWR_BUSY;
	logic [31:0] iWR_ADDR;
	cache_pkg::line_t iWR_DATA;
	logic iUP_REQ;
	cache_pkg::order_t iUP_ORDER;
	logic [31:0] iUP_ADDR, iUP_DATA;

	logic [21:0] m_tag [4][16];
	logic [1:0] m_stat [4][16];
	logic [7:0] m_data [4][16][64];
	int m_age;
	logic exp_req;
	logic exp_hit;
	logic [63:0] exp_data;
	logic exp_valid;
	logic exp_hit_out;
	logic [63:0] exp_dout;
	logic exp_busy, rd_acc;
	logic [31:0] lfsr = 32'he678;
	int errors = 0, tests = 0, bad_tests = 0, errs_before = 0, cycles = 0;

	l1_cache #(.AGE_PERIOD(AGE)) DUT (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #2 iCLOCK = ~iCLOCK;
	end

	// Busy and acceptance as the handshake rules define them
	assign exp_busy = iRD_BUSY || (iRD_REQ && iWR_REQ && iRD_ADDR[31:6] == iWR_ADDR[31:6]);
	assign rd_acc = iRD_REQ && !exp_busy;

	// Result masked while stalled, data zero unless hit
	assign exp_valid = exp_req && !iRD_BUSY;
	assign exp_hit_out = exp_valid && exp_hit;
	assign exp_dout = exp_hit_out ? exp_data : 64'd0;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [511:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr[0];	// One step per bit
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic logic [31:0] addr_of(input logic [21:0] tag, input logic [3:0] set);
		return {tag, set, 6'd0};
	endfunction

	function automatic int find_hit(input logic [31:0] a);
		for (int w = 0; w < 4; w++) begin
			if (m_stat[w][a[9:6]] != 2'd0 && m_tag[w][a[9:6]] == a[31:10]) return w;
		end
		return -1;
	endfunction

	function automatic int victim(input logic [31:0] a);
		for (int w = 0; w < 4; w++) begin
			if (m_tag[w][a[9:6]] == a[31:10]) return w;	// Known tag, any status
		end
		for (int lvl = 0; lvl < 3; lvl++) begin
			for (int w = 0; w < 4; w++) begin
				if (m_stat[w][a[9:6]] == 2'(lvl)) return w;
			end
		end
		return 3;
	endfunction

	function automatic int store_bytes(input cache_pkg::order_t o);
		return (o == 2'd0) ? 1 : (o == 2'd1) ? 2 : (o == 2'd2) ? 4 : 0;
	endfunction

	// Reference model, lookups on the state before the edge
	always @(posedge iCLOCK or negedge inRESET) begin : model
		int rw, uw, fw, off;
		logic tick;
		logic [63:0] dw;
		logic [511:0] fill_vec;
		if (!inRESET) begin
			foreach (m_stat[w, s]) m_stat[w][s] = 2'd0;
			m_age = 0;
			exp_req <= 1'b0;
			exp_hit <= 1'b0;
			exp_data <= '0;
		end
		else begin
			rw = find_hit(iRD_ADDR);
			uw = find_hit(iUP_ADDR);
			fw = victim(iWR_ADDR);
			fill_vec = iWR_DATA;
			if (iREMOVE) exp_req <= 1'b0;
			else if (!iRD_BUSY) exp_req <= rd_acc;	// Valid flag holds while stalled
			if (rd_acc) begin
				for (int k = 0; k < 8; k++) begin
					dw[8*k +: 8] = (rw >= 0) ? m_data[rw][iRD_ADDR[9:6]][8*iRD_ADDR[5:3] + k] : 8'd0;
				end
				exp_hit <= (rw >= 0);
				exp_data <= dw;
			end
			if (iREMOVE) begin
				foreach (m_stat[w, s]) m_stat[w][s] = 2'd0;
				m_age = 0;
			end
			else begin
				tick = !iRD_BUSY && m_age == AGE - 1;
				if (!iRD_BUSY) m_age = tick ? 0 : m_age + 1;
				if (iUP_REQ && uw >= 0) begin
					off = iUP_ADDR[5:0];
					for (int b = 0; b < store_bytes(iUP_ORDER) && off + b < 64; b++) begin
						m_data[uw][iUP_ADDR[9:6]][off + b] = iUP_DATA[8*((off + b) % 4) +: 8];
					end
					if (m_stat[uw][iUP_ADDR[9:6]] != 2'd3) m_stat[uw][iUP_ADDR[9:6]]++;
				end
				else if (iWR_REQ && !iUP_REQ) begin
					for (int b = 0; b < 64; b++) m_data[fw][iWR_ADDR[9:6]][b] = fill_vec[8*b +: 8];
					m_tag[fw][iWR_ADDR[9:6]] = iWR_ADDR[31:10];
					m_stat[fw][iWR_ADDR[9:6]] = 2'd3;
				end
				else if (!iRD_BUSY) begin
					if (tick) foreach (m_stat[w, s]) if (m_stat[w][s] > 2'd1) m_stat[w][s]--;
					if (rd_acc && rw >= 0) m_stat[rw][iRD_ADDR[9:6]] = 2'd3;
				end
			end
		end
	end

	task automatic report_value(input string sig, input logic [63:0] exp, input logic [63:0] got);
		$display("CHECK FAILED time %0t %s expected %h got %h", $time, sig, exp, got);
		errors++;
	endtask

	a_rd_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET) oRD_BUSY == exp_busy)
		else report_value("oRD_BUSY", $sampled(exp_busy), $sampled(oRD_BUSY));
	a_wr_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET) oWR_BUSY == iUP_REQ)
		else report_value("oWR_BUSY", $sampled(iUP_REQ), $sampled(oWR_BUSY));
	a_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		oRD_VALID == exp_valid)
		else report_value("oRD_VALID", $sampled(exp_valid), $sampled(oRD_VALID));
	a_hit: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		oRD_HIT == exp_hit_out)
		else report_value("oRD_HIT", $sampled(exp_hit_out), $sampled(oRD_HIT));
	a_data: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		oRD_DATA == exp_dout)
		else report_value("oRD_DATA", $sampled(exp_dout), $sampled(oRD_DATA));

	always @(posedge iCLOCK) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout after %0d cycles", cycles);
			$display("tests failed");
			$finish;
		end
	end

	task automatic read(input logic [31:0] a);
		@(negedge iCLOCK);
		iRD_REQ = 1'b1;
		iRD_ADDR = a;
		@(negedge iCLOCK);
		iRD_REQ = 1'b0;
	endtask

	task automatic read_line(input logic [31:0] a);
		for (int d = 0; d < 8; d++) read(a + 32'(8 * d));
	endtask

	task automatic fill(input logic [31:0] a);
		logic [511:0] v;
		rand_bits(512, v);
		@(negedge iCLOCK);
		iWR_REQ = 1'b1;
		iWR_ADDR = a;
		iWR_DATA = v;
		@(posedge iCLOCK);
		while (oWR_BUSY) @(posedge iCLOCK);	// Held until the store is gone
		@(negedge iCLOCK);
		iWR_REQ = 1'b0;
	endtask

	task automatic store(input logic [31:0] a, input cache_pkg::order_t o);
		logic [511:0] v;
		rand_bits(32, v);
		@(negedge iCLOCK);
		iUP_REQ = 1'b1;
		iUP_ADDR = a;
		iUP_ORDER = o;
		iUP_DATA = v[31:0];
		@(negedge iCLOCK);
		iUP_REQ = 1'b0;
	endtask

	task automatic end_test(input string name);
		repeat (2) @(negedge iCLOCK);
		tests++;
		if (errors > errs_before) bad_tests++;
		$display("test %0d %s: %s", tests, name, (errors > errs_before) ? "ERROR" : "ok");
		errs_before = errors;
	endtask

	initial begin
		inRESET = 1'b0;
		iREMOVE = 1'b0;
		iRD_REQ = 1'b0;
		iRD_BUSY = 1'b0;
		iRD_ADDR = '0;
		iWR_REQ = 1'b0;
		iWR_ADDR = '0;
		iWR_DATA = '0;
		iUP_REQ = 1'b0;
		iUP_ORDER = 2'd0;
		iUP_ADDR = '0;
		iUP_DATA = '0;
		repeat (3) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;

		read(addr_of(22'h1234, 4'd3));
		end_test("miss after reset");

		for (int w = 0; w < 4; w++) fill(addr_of(22'h100 + 22'(w), 4'd1));
		for (int w = 0; w < 4; w++) read_line(addr_of(22'h100 + 22'(w), 4'd1));
		fork	// Same line in one cycle, read must wait
			fill(addr_of(22'h100, 4'd1));
			read(addr_of(22'h100, 4'd1) + 32'd16);
		join
		read(addr_of(22'h100, 4'd1) + 32'd16);
		end_test("fill and read");

		fill(addr_of(22'h300, 4'd2));
		store(addr_of(22'h300, 4'd2) + 32'd7, 2'd0);
		store(addr_of(22'h300, 4'd2) + 32'd22, 2'd1);
		store(addr_of(22'h300, 4'd2) + 32'd40, 2'd2);
		store(addr_of(22'h300, 4'd2) + 32'd60, 2'd2);
		store(addr_of(22'h300, 4'd2) + 32'd13, 2'd3);
		store(addr_of(22'h301, 4'd2) + 32'd8, 2'd2);	// Miss
		read_line(addr_of(22'h300, 4'd2));
		fork
			fill(addr_of(22'h302, 4'd2));
			store(addr_of(22'h300, 4'd2) + 32'd33, 2'd0);
		join
		read_line(addr_of(22'h302, 4'd2));
		read(addr_of(22'h300, 4'd2) + 32'd32);
		end_test("store merge");

		for (int w = 0; w < 4; w++) fill(addr_of(22'h400 + 22'(w), 4'd5));
		repeat (2 * AGE + 4) @(negedge iCLOCK);
		read(addr_of(22'h400, 4'd5));
		fill(addr_of(22'h404, 4'd5));
		read(addr_of(22'h401, 4'd5));
		read(addr_of(22'h400, 4'd5) + 32'd8);
		read(addr_of(22'h404, 4'd5));
		end_test("replacement by age");

		@(negedge iCLOCK);
		iRD_REQ = 1'b1;
		iRD_ADDR = addr_of(22'h402, 4'd5) + 32'd24;
		@(negedge iCLOCK);
		iRD_REQ = 1'b0;
		iRD_BUSY = 1'b1;
		repeat (3) @(negedge iCLOCK);
		iRD_BUSY = 1'b0;
		end_test("back-pressure");

		@(negedge iCLOCK);
		iREMOVE = 1'b1;
		@(negedge iCLOCK);
		iREMOVE = 1'b0;
		for (int w = 0; w < 4; w++) read(addr_of(22'h100 + 22'(w), 4'd1));
		read(addr_of(22'h300, 4'd2));
		read(addr_of(22'h302, 4'd2));
		for (int w = 0; w < 5; w++) read(addr_of(22'h400 + 22'(w), 4'd5));
		end_test("flush");

		$display("%0d tests run, %0d with errors, %0d check errors", tests, bad_tests, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end
		else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
